//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = decodeUnitTb
FILELIST = project.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	-./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- project.f
verilog/decodePkg.sv
verilog/decodeCtrlIf.sv
verilog/opcodeDecoder.sv
verilog/immGenerator.sv
verilog/decodeStage.sv
verilog/rv32eDecodeUnit.sv
test/decodeUnitAssert.sv
test/decodeUnitTb.sv

//--- test/decodeUnitAssert.sv
`timescale 1ns/1ns
`default_nettype none

module decodeUnitAssert (
	input wire logic clk,
	input wire logic rstN,
	input wire logic outValid,
	input wire logic outReady,
	input wire logic instrValid,
	input wire logic instrReady,
	input wire logic [decodePkg::ALU_OP_W-1:0] aluOp,
	input wire logic [decodePkg::XLEN-1:0] imm,
	input wire logic [decodePkg::WB_SEL_W-1:0] wbSel,
	input wire logic [decodePkg::JUMP_W-1:0] jump,
	input wire logic trap,
	input wire logic [decodePkg::CAUSE_W-1:0] trapCause,
	input wire logic [decodePkg::REG_IDX_W-1:0] rd
);

	resetClearsValid: assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid high after reset");

	// Stalled bundle must not move
	holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> $stable(aluOp) && $stable(imm) && $stable(wbSel)
			&& $stable(jump) && $stable(trap) && $stable(trapCause) && $stable(rd))
		else $error("output bundle changed while stalled");

	// Accepted word is valid on the next edge
	acceptSetsValid: assert property (@(posedge clk) disable iff (!rstN)
		instrValid && instrReady |=> outValid)
		else $error("accepted instruction did not raise outValid");

endmodule

bind decodeStage decodeUnitAssert i_assert (
	.clk(clk),
	.rstN(rstN),
	.outValid(outValid),
	.outReady(outReady),
	.instrValid(instrValid),
	.instrReady(instrReady),
	.aluOp(aluOp),
	.imm(imm),
	.wbSel(wbSel),
	.jump(jump),
	.trap(trap),
	.trapCause(trapCause),
	.rd(rd)
);

`default_nettype wire

//--- test/decodeUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

module decodeUnitTb;

	typedef struct packed {
		logic [decodePkg::ALU_OP_W-1:0] aluOp;
		logic aluSrcPc;
		logic aluSrcImm;
		logic regWrite;
		logic [decodePkg::WB_SEL_W-1:0] wbSel;
		logic memValid;
		logic memWrite;
		logic [decodePkg::MASK_W-1:0] memMask;
		logic [decodePkg::MEM_RD_W-1:0] memRdSize;
		logic csrWrite;
		logic [decodePkg::CSR_SRC_W-1:0] csrSrc;
		logic [decodePkg::JUMP_W-1:0] jump;
		logic [decodePkg::REG_IDX_W-1:0] rd;
		logic [decodePkg::REG_IDX_W-1:0] rs1;
		logic [decodePkg::REG_IDX_W-1:0] rs2;
	} ctrlBundle_t;

	typedef struct packed {
		ctrlBundle_t ctrl;
		logic [decodePkg::XLEN-1:0] imm;
		logic trap;
		logic [decodePkg::CAUSE_W-1:0] cause;
	} decodeResult_t;

	logic clk;
	logic rstN;
	logic instrValid;
	logic instrReady;
	logic [decodePkg::XLEN-1:0] instr;
	logic outValid;
	logic outReady;
	logic [decodePkg::ALU_OP_W-1:0] aluOp;
	logic aluSrcPc;
	logic aluSrcImm;
	logic [decodePkg::XLEN-1:0] imm;
	logic regWrite;
	logic [decodePkg::WB_SEL_W-1:0] wbSel;
	logic memValid;
	logic memWrite;
	logic [decodePkg::MASK_W-1:0] memMask;
	logic [decodePkg::MEM_RD_W-1:0] memRdSize;
	logic csrWrite;
	logic [decodePkg::CSR_SRC_W-1:0] csrSrc;
	logic [decodePkg::JUMP_W-1:0] jump;
	logic trap;
	logic [decodePkg::CAUSE_W-1:0] trapCause;
	logic [decodePkg::REG_IDX_W-1:0] rd;
	logic [decodePkg::REG_IDX_W-1:0] rs1;
	logic [decodePkg::REG_IDX_W-1:0] rs2;

	logic [15:0] lfsrState = 16'd27;
	logic [decodePkg::XLEN-1:0] expectQ [$];
	logic acceptedLast = 1'b0;
	logic stalledLast = 1'b0;
	decodeResult_t heldResult;

	rv32eDecodeUnit i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stopRun();
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic valueMismatch(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		stopRun();
	endtask

	task automatic compareCtrl(input ctrlBundle_t expected, input ctrlBundle_t actual,
			input string what);
		if (actual !== expected)
			valueMismatch($sformatf("%s control got %h expected %h", what, actual, expected));
	endtask

	task automatic compareImm(input logic [decodePkg::XLEN-1:0] expected,
			input logic [decodePkg::XLEN-1:0] actual, input string what);
		if (actual !== expected)
			valueMismatch($sformatf("%s imm got %h expected %h", what, actual, expected));
	endtask

	task automatic compareTrap(input logic expTrap, input logic [decodePkg::CAUSE_W-1:0] expCause,
			input logic actTrap, input logic [decodePkg::CAUSE_W-1:0] actCause, input string what);
		if (actTrap !== expTrap || actCause !== expCause)
			valueMismatch($sformatf("%s trap got %b/%0d expected %b/%0d", what, actTrap,
				actCause, expTrap, expCause));
	endtask

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic logic [6:0] legalOpcode(input logic [3:0] idx);
		case (idx)
			4'd0: return decodePkg::OP_SYSTEM;
			4'd1: return decodePkg::OP_IMM;
			4'd2: return decodePkg::OP_REG;
			4'd3: return decodePkg::OP_STORE;
			4'd4: return decodePkg::OP_LOAD;
			4'd5: return decodePkg::OP_BRANCH;
			4'd6: return decodePkg::OP_AUIPC;
			4'd7: return decodePkg::OP_LUI;
			4'd8: return decodePkg::OP_JAL;
			default: return decodePkg::OP_JALR;
		endcase
	endfunction

	function automatic logic [31:0] makeInstr();
		logic [31:0] w;
		logic [3:0] pick;
		w = randBits(32);
		pick = 4'(randBits(4));
		if (pick < 4'd10)
			w[6:0] = legalOpcode(pick);
		else
			w[6:0] = 7'(randBits(7));
		// Steer funct fields toward legal encodings
		if (w[6:0] == decodePkg::OP_SYSTEM) begin
			if (randBits(1) != 0)
				w[14:12] = decodePkg::F3_PRIV;
			case (randBits(2))
				0: w[31:20] = decodePkg::F12_ECALL;
				1: w[31:20] = decodePkg::F12_EBREAK;
				2: w[31:20] = decodePkg::F12_MRET;
				default: ;
			endcase
		end else if (w[6:0] == decodePkg::OP_REG || w[6:0] == decodePkg::OP_IMM) begin
			case (randBits(2))
				0: w[31:25] = decodePkg::F7_BASE;
				1: w[31:25] = decodePkg::F7_ALT;
				default: ;
			endcase
		end
		return w;
	endfunction

	function automatic decodeResult_t refDecode(input logic [decodePkg::XLEN-1:0] w);
		decodeResult_t r;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [decodePkg::IMM_TYPE_W-1:0] kind;
		logic [decodePkg::ALU_OP_W-1:0] op;
		logic legal;
		f3 = w[14:12];
		f7 = w[31:25];
		kind = decodePkg::IMM_I;
		op = decodePkg::ALU_ADD;
		legal = 1'b1;
		r = '0;
		r.ctrl.aluOp = decodePkg::ALU_ADD;
		r.ctrl.wbSel = decodePkg::WB_ALU;
		r.ctrl.memRdSize = decodePkg::RD_WORD;
		r.ctrl.csrSrc = decodePkg::CSR_RS1;
		r.ctrl.jump = decodePkg::JMP_NONE;
		r.ctrl.rd = w[10:7];
		r.ctrl.rs1 = w[18:15];
		r.ctrl.rs2 = w[23:20];
		case (w[6:0])
			decodePkg::OP_SYSTEM: begin
				if (f3 == decodePkg::F3_CSRRW || f3 == decodePkg::F3_CSRRS) begin
					r.ctrl.csrWrite = 1'b1;
					r.ctrl.regWrite = 1'b1;
					r.ctrl.wbSel = decodePkg::WB_CSR;
					if (f3 == decodePkg::F3_CSRRS)
						r.ctrl.csrSrc = decodePkg::CSR_RS1_OR;
				end else if (f3 == decodePkg::F3_PRIV && w[31:20] == decodePkg::F12_ECALL) begin
					r.trap = 1'b1;
					r.cause = decodePkg::CAUSE_ECALL;
					r.ctrl.csrSrc = decodePkg::CSR_PC;
				end else if (f3 == decodePkg::F3_PRIV && w[31:20] == decodePkg::F12_EBREAK) begin
					r.trap = 1'b1;
					r.cause = decodePkg::CAUSE_BREAK;
				end else if (f3 == decodePkg::F3_PRIV && w[31:20] == decodePkg::F12_MRET) begin
					r.ctrl.jump = decodePkg::JMP_MRET;
				end
			end
			decodePkg::OP_IMM, decodePkg::OP_REG: begin
				case (f3)
					decodePkg::F3_ADD: begin
						if (w[6:0] == decodePkg::OP_REG && f7 == decodePkg::F7_ALT)
							op = decodePkg::ALU_SUB;
						else if (w[6:0] == decodePkg::OP_REG && f7 != decodePkg::F7_BASE)
							legal = 1'b0;
					end
					decodePkg::F3_SLL: op = decodePkg::ALU_SLL;
					decodePkg::F3_SLT: op = decodePkg::ALU_CMP;
					decodePkg::F3_SLTU: op = decodePkg::ALU_CMPU;
					decodePkg::F3_XOR: op = decodePkg::ALU_XOR;
					decodePkg::F3_OR: op = decodePkg::ALU_OR;
					decodePkg::F3_AND: op = decodePkg::ALU_AND;
					default: begin
						if (f7 == decodePkg::F7_BASE)
							op = decodePkg::ALU_SRL;
						else if (f7 == decodePkg::F7_ALT)
							op = decodePkg::ALU_SRA;
						else
							legal = 1'b0;
					end
				endcase
				if (legal) begin
					r.ctrl.aluOp = op;
					r.ctrl.aluSrcImm = (w[6:0] == decodePkg::OP_IMM);
					r.ctrl.regWrite = 1'b1;
				end
			end
			decodePkg::OP_STORE: begin
				case (f3)
					decodePkg::F3_SB: r.ctrl.memMask = decodePkg::MASK_BYTE;
					decodePkg::F3_SH: r.ctrl.memMask = decodePkg::MASK_HALF;
					decodePkg::F3_SW: r.ctrl.memMask = decodePkg::MASK_WORD;
					default: ;
				endcase
				if (r.ctrl.memMask != '0) begin
					r.ctrl.memValid = 1'b1;
					r.ctrl.memWrite = 1'b1;
					r.ctrl.aluSrcImm = 1'b1;
					kind = decodePkg::IMM_S;
				end
			end
			decodePkg::OP_LOAD: begin
				case (f3)
					decodePkg::F3_LB: r.ctrl.memRdSize = decodePkg::RD_BYTE;
					decodePkg::F3_LH: r.ctrl.memRdSize = decodePkg::RD_HALF;
					decodePkg::F3_LW: r.ctrl.memRdSize = decodePkg::RD_WORD;
					decodePkg::F3_LBU: r.ctrl.memRdSize = decodePkg::RD_BYTEU;
					decodePkg::F3_LHU: r.ctrl.memRdSize = decodePkg::RD_HALFU;
					default: legal = 1'b0;
				endcase
				if (legal) begin
					r.ctrl.memValid = 1'b1;
					r.ctrl.memMask = decodePkg::MASK_WORD;
					r.ctrl.aluSrcImm = 1'b1;
					r.ctrl.regWrite = 1'b1;
					r.ctrl.wbSel = decodePkg::WB_MEM;
				end
			end
			decodePkg::OP_BRANCH: begin
				case (f3)
					decodePkg::F3_BEQ: r.ctrl.jump = decodePkg::JMP_EQ;
					decodePkg::F3_BNE: r.ctrl.jump = decodePkg::JMP_NE;
					decodePkg::F3_BLT: r.ctrl.jump = decodePkg::JMP_LT;
					decodePkg::F3_BGE: r.ctrl.jump = decodePkg::JMP_GE;
					decodePkg::F3_BLTU: r.ctrl.jump = decodePkg::JMP_LTU;
					decodePkg::F3_BGEU: r.ctrl.jump = decodePkg::JMP_GEU;
					default: ;
				endcase
				// Signed compare for blt/bge, unsigned for bltu/bgeu
				if (f3 == decodePkg::F3_BEQ || f3 == decodePkg::F3_BNE)
					op = decodePkg::ALU_SUB;
				else if (f3 == decodePkg::F3_BLT || f3 == decodePkg::F3_BGE)
					op = decodePkg::ALU_CMP;
				else
					op = decodePkg::ALU_CMPU;
				if (r.ctrl.jump != decodePkg::JMP_NONE) begin
					r.ctrl.aluOp = op;
					kind = decodePkg::IMM_B;
				end
			end
			decodePkg::OP_AUIPC: begin
				r.ctrl.aluSrcPc = 1'b1;
				r.ctrl.aluSrcImm = 1'b1;
				r.ctrl.regWrite = 1'b1;
				kind = decodePkg::IMM_U;
			end
			decodePkg::OP_LUI: begin
				r.ctrl.regWrite = 1'b1;
				r.ctrl.wbSel = decodePkg::WB_IMM;
				kind = decodePkg::IMM_U;
			end
			decodePkg::OP_JAL: begin
				r.ctrl.aluSrcPc = 1'b1;
				r.ctrl.aluSrcImm = 1'b1;
				r.ctrl.regWrite = 1'b1;
				r.ctrl.wbSel = decodePkg::WB_LINK;
				r.ctrl.jump = decodePkg::JMP_JAL;
				kind = decodePkg::IMM_J;
			end
			decodePkg::OP_JALR: begin
				r.ctrl.aluSrcImm = 1'b1;
				r.ctrl.regWrite = 1'b1;
				r.ctrl.wbSel = decodePkg::WB_LINK;
				r.ctrl.jump = decodePkg::JMP_JALR;
			end
			default: ;
		endcase
		case (kind)
			decodePkg::IMM_S: r.imm = {{21{w[31]}}, w[30:25], w[11:7]};
			decodePkg::IMM_B: r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			decodePkg::IMM_U: r.imm = {w[31:12], 12'h000};
			decodePkg::IMM_J: r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			default: r.imm = {{21{w[31]}}, w[30:20]};
		endcase
		return r;
	endfunction

	function automatic decodeResult_t captureOutputs();
		decodeResult_t r;
		r.ctrl = {aluOp, aluSrcPc, aluSrcImm, regWrite, wbSel, memValid, memWrite, memMask,
			memRdSize, csrWrite, csrSrc, jump, rd, rs1, rs2};
		r.imm = imm;
		r.trap = trap;
		r.cause = trapCause;
		return r;
	endfunction

	// Values seen here are the ones before this edge updates the DUT
	always @(posedge clk) begin
		decodeResult_t act;
		decodeResult_t exp;
		logic [decodePkg::XLEN-1:0] word;
		act = captureOutputs();
		if (rstN) begin
			if (acceptedLast && outValid !== 1'b1)
				valueMismatch("no output one cycle after acceptance");
			if (stalledLast) begin
				compareCtrl(heldResult.ctrl, act.ctrl, "Stalled output");
				compareImm(heldResult.imm, act.imm, "Stalled output");
				compareTrap(heldResult.trap, heldResult.cause, act.trap, act.cause,
					"Stalled output");
			end
			if (outValid && outReady) begin
				if (expectQ.size() == 0) begin
					$display("Output handshake at %0t ns with no instruction pending", $time);
					stopRun();
				end else begin
					word = expectQ.pop_front();
					exp = refDecode(word);
					compareCtrl(exp.ctrl, act.ctrl, $sformatf("Instruction %h", word));
					compareImm(exp.imm, act.imm, $sformatf("Instruction %h", word));
					compareTrap(exp.trap, exp.cause, act.trap, act.cause,
						$sformatf("Instruction %h", word));
				end
			end
			stalledLast = outValid && !outReady;
			heldResult = act;
			acceptedLast = instrValid && instrReady;
			if (acceptedLast)
				expectQ.push_back(instr);
		end
	end

	initial begin
		int waitCycles;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		outReady = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		if (outValid !== 1'b0 || instrReady !== 1'b1)
			valueMismatch("handshake not idle after reset");
		for (int n = 0; n < 600; n++) begin
			// Occasional idle cycle between words
			if (randBits(2) == 0) begin
				instrValid = 1'b0;
				outReady = 1'(randBits(1));
				@(negedge clk);
			end
			instrValid = 1'b1;
			instr = makeInstr();
			outReady = 1'(randBits(1));
			waitCycles = 0;
			@(posedge clk);
			while (instrReady !== 1'b1 && waitCycles < 20) begin
				@(negedge clk);
				outReady = 1'(randBits(1));
				@(posedge clk);
				waitCycles++;
			end
			if (instrReady !== 1'b1) begin
				$display("Timeout: instruction %h was never accepted", instr);
				stopRun();
			end
			@(negedge clk);
		end
		instrValid = 1'b0;
		outReady = 1'b1;
		waitCycles = 0;
		while ((expectQ.size() != 0 || outValid !== 1'b0) && waitCycles < 20) begin
			@(negedge clk);
			waitCycles++;
		end
		if (expectQ.size() == 0 && outValid === 1'b0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Timeout: %0d accepted instructions never produced an output",
				expectQ.size());
			stopRun();
		end
	end

endmodule

`default_nettype wire

//--- verilog/decodeCtrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface decodeCtrlIf;

	decodePkg::instrWord_u instr;
	logic [decodePkg::ALU_OP_W-1:0] aluOp;
	logic aluSrcPc;
	logic aluSrcImm;
	logic [decodePkg::IMM_TYPE_W-1:0] immType;
	logic [decodePkg::XLEN-1:0] imm;
	logic regWrite;
	logic [decodePkg::WB_SEL_W-1:0] wbSel;
	logic memValid;
	logic memWrite;
	logic [decodePkg::MASK_W-1:0] memMask;
	logic [decodePkg::MEM_RD_W-1:0] memRdSize;
	logic csrWrite;
	logic [decodePkg::CSR_SRC_W-1:0] csrSrc;
	logic [decodePkg::JUMP_W-1:0] jump;
	logic trap;
	logic [decodePkg::CAUSE_W-1:0] trapCause;
	logic [decodePkg::REG_IDX_W-1:0] rd;
	logic [decodePkg::REG_IDX_W-1:0] rs1;
	logic [decodePkg::REG_IDX_W-1:0] rs2;

	modport decoder (
		input instr,
		output aluOp, aluSrcPc, aluSrcImm, immType, regWrite, wbSel,
		output memValid, memWrite, memMask, memRdSize, csrWrite, csrSrc,
		output jump, trap, trapCause, rd, rs1, rs2
	);

	modport immGen (
		input instr, immType,
		output imm
	);

	modport stage (
		output instr,
		input aluOp, aluSrcPc, aluSrcImm, immType, imm, regWrite, wbSel,
		input memValid, memWrite, memMask, memRdSize, csrWrite, csrSrc,
		input jump, trap, trapCause, rd, rs1, rs2
	);

endinterface

`default_nettype wire

//--- verilog/decodePkg.sv
`default_nettype none

package decodePkg;

	localparam int XLEN = 32;
	localparam int REG_IDX_W = 4;
	localparam int ALU_OP_W = 4;
	localparam int IMM_TYPE_W = 3;
	localparam int WB_SEL_W = 3;
	localparam int MEM_RD_W = 3;
	localparam int CSR_SRC_W = 2;
	localparam int JUMP_W = 4;
	localparam int MASK_W = 8;
	localparam int CAUSE_W = 8;
	localparam int OPCODE_W = 7;
	localparam int FUNCT3_W = 3;
	localparam int FUNCT7_W = 7;
	localparam int FUNCT12_W = 12;

	localparam logic [OPCODE_W-1:0] OP_SYSTEM = 7'b1110011;
	localparam logic [OPCODE_W-1:0] OP_IMM = 7'b0010011;
	localparam logic [OPCODE_W-1:0] OP_REG = 7'b0110011;
	localparam logic [OPCODE_W-1:0] OP_STORE = 7'b0100011;
	localparam logic [OPCODE_W-1:0] OP_LOAD = 7'b0000011;
	localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
	localparam logic [OPCODE_W-1:0] OP_AUIPC = 7'b0010111;
	localparam logic [OPCODE_W-1:0] OP_LUI = 7'b0110111;
	localparam logic [OPCODE_W-1:0] OP_JAL = 7'b1101111;
	localparam logic [OPCODE_W-1:0] OP_JALR = 7'b1100111;

	localparam logic [FUNCT12_W-1:0] F12_ECALL = 12'h000;
	localparam logic [FUNCT12_W-1:0] F12_EBREAK = 12'h001;
	localparam logic [FUNCT12_W-1:0] F12_MRET = 12'h302;

	// SYSTEM
	localparam logic [FUNCT3_W-1:0] F3_PRIV = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_CSRRW = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_CSRRS = 3'b010;
	// Shared by register and immediate arithmetic
	localparam logic [FUNCT3_W-1:0] F3_ADD = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SLL = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SLT = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
	localparam logic [FUNCT3_W-1:0] F3_XOR = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_SR = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_OR = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_AND = 3'b111;
	localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
	localparam logic [FUNCT7_W-1:0] F7_ALT = 7'b0100000;
	// Loads and stores
	localparam logic [FUNCT3_W-1:0] F3_SB = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SH = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SW = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_LB = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_LH = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_LW = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_LBU = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_LHU = 3'b101;
	// Branches
	localparam logic [FUNCT3_W-1:0] F3_BEQ = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_BNE = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_BLT = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_BGE = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'b0000;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'b0001;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'b0010;
	localparam logic [ALU_OP_W-1:0] ALU_CMP = 4'b0011;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'b0100;
	localparam logic [ALU_OP_W-1:0] ALU_CMPU = 4'b0101;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 4'b0110;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'b0111;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'b1000;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'b1001;

	localparam logic [IMM_TYPE_W-1:0] IMM_I = 3'b000;
	localparam logic [IMM_TYPE_W-1:0] IMM_U = 3'b001;
	localparam logic [IMM_TYPE_W-1:0] IMM_J = 3'b010;
	localparam logic [IMM_TYPE_W-1:0] IMM_S = 3'b011;
	localparam logic [IMM_TYPE_W-1:0] IMM_B = 3'b100;

	localparam logic [WB_SEL_W-1:0] WB_ALU = 3'b000;
	localparam logic [WB_SEL_W-1:0] WB_IMM = 3'b001;
	localparam logic [WB_SEL_W-1:0] WB_LINK = 3'b010;
	localparam logic [WB_SEL_W-1:0] WB_MEM = 3'b011;
	localparam logic [WB_SEL_W-1:0] WB_CSR = 3'b100;

	localparam logic [CSR_SRC_W-1:0] CSR_RS1 = 2'b00;
	localparam logic [CSR_SRC_W-1:0] CSR_RS1_OR = 2'b01;
	localparam logic [CSR_SRC_W-1:0] CSR_PC = 2'b10;

	localparam logic [MEM_RD_W-1:0] RD_BYTE = 3'b000;
	localparam logic [MEM_RD_W-1:0] RD_HALF = 3'b001;
	localparam logic [MEM_RD_W-1:0] RD_WORD = 3'b010;
	localparam logic [MEM_RD_W-1:0] RD_BYTEU = 3'b011;
	localparam logic [MEM_RD_W-1:0] RD_HALFU = 3'b100;

	localparam logic [MASK_W-1:0] MASK_BYTE = 8'b00000001;
	localparam logic [MASK_W-1:0] MASK_HALF = 8'b00000011;
	localparam logic [MASK_W-1:0] MASK_WORD = 8'b00001111;

	localparam logic [JUMP_W-1:0] JMP_EQ = 4'b0000;
	localparam logic [JUMP_W-1:0] JMP_NE = 4'b0001;
	localparam logic [JUMP_W-1:0] JMP_LT = 4'b0100;
	localparam logic [JUMP_W-1:0] JMP_GE = 4'b0101;
	localparam logic [JUMP_W-1:0] JMP_LTU = 4'b0110;
	localparam logic [JUMP_W-1:0] JMP_GEU = 4'b0111;
	localparam logic [JUMP_W-1:0] JMP_JAL = 4'b1000;
	localparam logic [JUMP_W-1:0] JMP_JALR = 4'b1001;
	localparam logic [JUMP_W-1:0] JMP_MRET = 4'b1010;
	localparam logic [JUMP_W-1:0] JMP_NONE = 4'b1111;

	localparam logic [CAUSE_W-1:0] CAUSE_BREAK = 8'd3;
	localparam logic [CAUSE_W-1:0] CAUSE_ECALL = 8'd11;

	// R view for funct7, I view for funct12
	typedef union packed {
		struct packed {
			logic [FUNCT7_W-1:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [FUNCT3_W-1:0] funct3;
			logic [4:0] rd;
			logic [OPCODE_W-1:0] opcode;
		} r;
		struct packed {
			logic [FUNCT12_W-1:0] funct12;
			logic [4:0] rs1;
			logic [FUNCT3_W-1:0] funct3;
			logic [4:0] rd;
			logic [OPCODE_W-1:0] opcode;
		} i;
	} instrWord_u;

endpackage

`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
	input wire logic clk,
	input wire logic rstN,
	input wire logic instrValid,
	output logic instrReady,
	input wire decodePkg::instrWord_u instrIn,
	decodeCtrlIf.stage ctrl,
	output logic outValid,
	input wire logic outReady,
	output logic [decodePkg::ALU_OP_W-1:0] aluOp,
	output logic aluSrcPc,
	output logic aluSrcImm,
	output logic [decodePkg::XLEN-1:0] imm,
	output logic regWrite,
	output logic [decodePkg::WB_SEL_W-1:0] wbSel,
	output logic memValid,
	output logic memWrite,
	output logic [decodePkg::MASK_W-1:0] memMask,
	output logic [decodePkg::MEM_RD_W-1:0] memRdSize,
	output logic csrWrite,
	output logic [decodePkg::CSR_SRC_W-1:0] csrSrc,
	output logic [decodePkg::JUMP_W-1:0] jump,
	output logic trap,
	output logic [decodePkg::CAUSE_W-1:0] trapCause,
	output logic [decodePkg::REG_IDX_W-1:0] rd,
	output logic [decodePkg::REG_IDX_W-1:0] rs1,
	output logic [decodePkg::REG_IDX_W-1:0] rs2
);

	logic accept;

	// Decoder sees the incoming word directly
	assign ctrl.instr = instrIn;

	assign instrReady = !outValid || outReady;
	assign accept = instrValid && instrReady;

	always_ff @(posedge clk) begin
		if (!rstN)
			outValid <= 1'b0;
		else if (accept)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			aluOp <= ctrl.aluOp;
			aluSrcPc <= ctrl.aluSrcPc;
			aluSrcImm <= ctrl.aluSrcImm;
			imm <= ctrl.imm;
			regWrite <= ctrl.regWrite;
			wbSel <= ctrl.wbSel;
			memValid <= ctrl.memValid;
			memWrite <= ctrl.memWrite;
			memMask <= ctrl.memMask;
			memRdSize <= ctrl.memRdSize;
			csrWrite <= ctrl.csrWrite;
			csrSrc <= ctrl.csrSrc;
			jump <= ctrl.jump;
			trap <= ctrl.trap;
			trapCause <= ctrl.trapCause;
			rd <= ctrl.rd;
			rs1 <= ctrl.rs1;
			rs2 <= ctrl.rs2;
		end
	end

endmodule

`default_nettype wire

//--- verilog/immGenerator.sv
`timescale 1ns/1ns
`default_nettype none

module immGenerator (
	decodeCtrlIf.immGen ctrl
);

	logic [decodePkg::XLEN-1:0] raw;

	assign raw = ctrl.instr;

	always_comb begin
		case (ctrl.immType)
			decodePkg::IMM_S: begin
				ctrl.imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
			end
			// Branch offset, halfword aligned
			decodePkg::IMM_B: begin
				ctrl.imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
			end
			decodePkg::IMM_U: begin
				ctrl.imm = {raw[31:12], 12'b0};
			end
			decodePkg::IMM_J: begin
				ctrl.imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
			end
			default: begin
				ctrl.imm = {{20{raw[31]}}, raw[31:20]};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/opcodeDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module opcodeDecoder (
	decodeCtrlIf.decoder ctrl
);

	logic [decodePkg::ALU_OP_W-1:0] arithOp;
	logic arithLegal;

	// RV32E, bit 4 of each register field dropped
	assign ctrl.rd = ctrl.instr.r.rd[decodePkg::REG_IDX_W-1:0];
	assign ctrl.rs1 = ctrl.instr.r.rs1[decodePkg::REG_IDX_W-1:0];
	assign ctrl.rs2 = ctrl.instr.r.rs2[decodePkg::REG_IDX_W-1:0];

	// Common ALU op for OP and OP-IMM
	always_comb begin
		arithLegal = 1'b1;
		arithOp = decodePkg::ALU_ADD;
		case (ctrl.instr.r.funct3)
			decodePkg::F3_ADD: begin
				if (ctrl.instr.r.opcode == decodePkg::OP_REG) begin
					if (ctrl.instr.r.funct7 == decodePkg::F7_ALT)
						arithOp = decodePkg::ALU_SUB;
					else if (ctrl.instr.r.funct7 != decodePkg::F7_BASE)
						arithLegal = 1'b0;
				end
			end
			decodePkg::F3_SLL: arithOp = decodePkg::ALU_SLL;
			decodePkg::F3_SLT: arithOp = decodePkg::ALU_CMP;
			decodePkg::F3_SLTU: arithOp = decodePkg::ALU_CMPU;
			decodePkg::F3_XOR: arithOp = decodePkg::ALU_XOR;
			decodePkg::F3_SR: begin
				if (ctrl.instr.r.funct7 == decodePkg::F7_BASE)
					arithOp = decodePkg::ALU_SRL;
				else if (ctrl.instr.r.funct7 == decodePkg::F7_ALT)
					arithOp = decodePkg::ALU_SRA;
				else
					arithLegal = 1'b0;
			end
			decodePkg::F3_OR: arithOp = decodePkg::ALU_OR;
			default: arithOp = decodePkg::ALU_AND;
		endcase
	end

	always_comb begin
		// Inert bundle unless an encoding below matches
		ctrl.aluOp = decodePkg::ALU_ADD;
		ctrl.aluSrcPc = 1'b0;
		ctrl.aluSrcImm = 1'b0;
		ctrl.immType = decodePkg::IMM_I;
		ctrl.regWrite = 1'b0;
		ctrl.wbSel = decodePkg::WB_ALU;
		ctrl.memValid = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memMask = '0;
		ctrl.memRdSize = decodePkg::RD_WORD;
		ctrl.csrWrite = 1'b0;
		ctrl.csrSrc = decodePkg::CSR_RS1;
		ctrl.jump = decodePkg::JMP_NONE;
		ctrl.trap = 1'b0;
		ctrl.trapCause = '0;
		case (ctrl.instr.r.opcode)
			decodePkg::OP_SYSTEM: begin
				case (ctrl.instr.i.funct3)
					decodePkg::F3_CSRRW, decodePkg::F3_CSRRS: begin
						ctrl.csrWrite = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.wbSel = decodePkg::WB_CSR;
						if (ctrl.instr.i.funct3 == decodePkg::F3_CSRRS)
							ctrl.csrSrc = decodePkg::CSR_RS1_OR;
					end
					decodePkg::F3_PRIV: begin
						case (ctrl.instr.i.funct12)
							decodePkg::F12_ECALL: begin
								ctrl.trap = 1'b1;
								ctrl.trapCause = decodePkg::CAUSE_ECALL;
								ctrl.csrSrc = decodePkg::CSR_PC;
							end
							decodePkg::F12_EBREAK: begin
								ctrl.trap = 1'b1;
								ctrl.trapCause = decodePkg::CAUSE_BREAK;
							end
							decodePkg::F12_MRET: ctrl.jump = decodePkg::JMP_MRET;
							default: ;
						endcase
					end
					default: ;
				endcase
			end
			decodePkg::OP_IMM, decodePkg::OP_REG: begin
				if (arithLegal) begin
					ctrl.aluOp = arithOp;
					ctrl.aluSrcImm = (ctrl.instr.r.opcode == decodePkg::OP_IMM);
					ctrl.regWrite = 1'b1;
				end
			end
			decodePkg::OP_STORE: begin
				if (ctrl.instr.r.funct3 inside {decodePkg::F3_SB, decodePkg::F3_SH,
						decodePkg::F3_SW}) begin
					ctrl.memValid = 1'b1;
					ctrl.memWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.immType = decodePkg::IMM_S;
					case (ctrl.instr.r.funct3)
						decodePkg::F3_SB: ctrl.memMask = decodePkg::MASK_BYTE;
						decodePkg::F3_SH: ctrl.memMask = decodePkg::MASK_HALF;
						default: ctrl.memMask = decodePkg::MASK_WORD;
					endcase
				end
			end
			decodePkg::OP_LOAD: begin
				if (ctrl.instr.r.funct3 inside {decodePkg::F3_LB, decodePkg::F3_LH,
						decodePkg::F3_LW, decodePkg::F3_LBU, decodePkg::F3_LHU}) begin
					ctrl.memValid = 1'b1;
					ctrl.memMask = decodePkg::MASK_WORD;
					ctrl.aluSrcImm = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.wbSel = decodePkg::WB_MEM;
					case (ctrl.instr.r.funct3)
						decodePkg::F3_LB: ctrl.memRdSize = decodePkg::RD_BYTE;
						decodePkg::F3_LH: ctrl.memRdSize = decodePkg::RD_HALF;
						decodePkg::F3_LBU: ctrl.memRdSize = decodePkg::RD_BYTEU;
						decodePkg::F3_LHU: ctrl.memRdSize = decodePkg::RD_HALFU;
						default: ctrl.memRdSize = decodePkg::RD_WORD;
					endcase
				end
			end
			decodePkg::OP_BRANCH: begin
				case (ctrl.instr.r.funct3)
					decodePkg::F3_BEQ: ctrl.jump = decodePkg::JMP_EQ;
					decodePkg::F3_BNE: ctrl.jump = decodePkg::JMP_NE;
					decodePkg::F3_BLT: ctrl.jump = decodePkg::JMP_LT;
					decodePkg::F3_BGE: ctrl.jump = decodePkg::JMP_GE;
					decodePkg::F3_BLTU: ctrl.jump = decodePkg::JMP_LTU;
					decodePkg::F3_BGEU: ctrl.jump = decodePkg::JMP_GEU;
					default: ;
				endcase
				// Equality compares by subtraction
				if (ctrl.jump != decodePkg::JMP_NONE) begin
					ctrl.immType = decodePkg::IMM_B;
					if (ctrl.instr.r.funct3[2:1] == 2'b00)
						ctrl.aluOp = decodePkg::ALU_SUB;
					else if (ctrl.instr.r.funct3[1])
						ctrl.aluOp = decodePkg::ALU_CMPU;
					else
						ctrl.aluOp = decodePkg::ALU_CMP;
				end
			end
			decodePkg::OP_AUIPC: begin
				ctrl.aluSrcPc = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.immType = decodePkg::IMM_U;
			end
			decodePkg::OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.immType = decodePkg::IMM_U;
				ctrl.wbSel = decodePkg::WB_IMM;
			end
			decodePkg::OP_JAL: begin
				ctrl.aluSrcPc = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.immType = decodePkg::IMM_J;
				ctrl.wbSel = decodePkg::WB_LINK;
				ctrl.jump = decodePkg::JMP_JAL;
			end
			decodePkg::OP_JALR: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = decodePkg::WB_LINK;
				ctrl.jump = decodePkg::JMP_JALR;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rv32eDecodeUnit.sv
`timescale 1ns/1ns
`default_nettype none

module rv32eDecodeUnit (
	input wire logic clk,
	input wire logic rstN,
	input wire logic instrValid,
	output logic instrReady,
	input wire logic [decodePkg::XLEN-1:0] instr,
	output logic outValid,
	input wire logic outReady,
	output logic [decodePkg::ALU_OP_W-1:0] aluOp,
	output logic aluSrcPc,
	output logic aluSrcImm,
	output logic [decodePkg::XLEN-1:0] imm,
	output logic regWrite,
	output logic [decodePkg::WB_SEL_W-1:0] wbSel,
	output logic memValid,
	output logic memWrite,
	output logic [decodePkg::MASK_W-1:0] memMask,
	output logic [decodePkg::MEM_RD_W-1:0] memRdSize,
	output logic csrWrite,
	output logic [decodePkg::CSR_SRC_W-1:0] csrSrc,
	output logic [decodePkg::JUMP_W-1:0] jump,
	output logic trap,
	output logic [decodePkg::CAUSE_W-1:0] trapCause,
	output logic [decodePkg::REG_IDX_W-1:0] rd,
	output logic [decodePkg::REG_IDX_W-1:0] rs1,
	output logic [decodePkg::REG_IDX_W-1:0] rs2
);

	decodeCtrlIf ctrlIf ();

	opcodeDecoder i_decoder (
		.ctrl(ctrlIf)
	);

	immGenerator i_immGen (
		.ctrl(ctrlIf)
	);

	decodeStage i_stage (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.instrIn(instr),
		.ctrl(ctrlIf),
		.outValid(outValid),
		.outReady(outReady),
		.aluOp(aluOp),
		.aluSrcPc(aluSrcPc),
		.aluSrcImm(aluSrcImm),
		.imm(imm),
		.regWrite(regWrite),
		.wbSel(wbSel),
		.memValid(memValid),
		.memWrite(memWrite),
		.memMask(memMask),
		.memRdSize(memRdSize),
		.csrWrite(csrWrite),
		.csrSrc(csrSrc),
		.jump(jump),
		.trap(trap),
		.trapCause(trapCause),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2)
	);

endmodule

`default_nettype wire
